/* source/riscv_pkg.sv */
package riscv_pkg;

  localparam int XLEN = 32;

  // ------------------------------
  // Encodings
  // ------------------------------
  typedef enum logic [2:0] {
    ALU,
    SFT,
    BU,
    LSU,
    NONE
  } unit_e;

  typedef enum logic [3:0] {
    ADD, SUB, AND, OR, XOR, SLT,
    SLL, SRL, SRA,
    BEQ, BNE, BLT, JAL, JALR,
    LD, ST
  } op_e;

  typedef enum logic [1:0] {
    BYTE,
    HALF,
    WORD
  } size_e;

  typedef enum logic [1:0] {
    USER    = 2'd0,
    SUPER   = 2'd1,
    MACHINE = 2'd3
  } mode_e;

  // mcause codes
  typedef enum logic [XLEN-1:0] {
    PC_MISALIGNED = 32'd0,
    ILLEGAL       = 32'd2,
    LD_MISALIGNED = 32'd4,
    ST_MISALIGNED = 32'd6,
    ECALL_M       = 32'd11
  } cause_e;

  // ------------------------------
  // Packets
  // ------------------------------
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            rd_v;
    logic [4:0]      rd_adr;
    logic [XLEN-1:0] rs1;
    logic [XLEN-1:0] rs2;
    logic [XLEN-1:0] imm;
    size_e           size;
    logic            unsign;
    unit_e           unit;
    op_e             op;
    logic            csr_wbk;
    logic            csrrw;
    logic [11:0]     csr_adr;
    logic            illegal;
    logic            ecall;
    logic            mret;
    logic            sret;
  } dec_pkt_t;

  typedef struct packed {
    logic            rd_v;
    logic [4:0]      rd_adr;
    logic [XLEN-1:0] rd_data;
    logic            csr_v;
    logic [11:0]     csr_adr;
    logic [XLEN-1:0] csr_data;
    logic            branch_v;
    logic [XLEN-1:0] pc_nxt;
  } wbk_pkt_t;

  typedef struct packed {
    logic            exception;
    cause_e          cause;
    logic [XLEN-1:0] mtval;
    logic [XLEN-1:0] mepc;
  } trap_pkt_t;

  typedef struct packed {
    logic            valid;
    logic            store;
    logic [XLEN-1:0] adr;
    size_e           size;
    logic [XLEN-1:0] wdata;
  } mem_req_t;

endpackage

/* source/alu.sv */
`timescale 1ns/100ps

module alu import riscv_pkg::*; (
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  op_e             op_i,
  output logic [XLEN-1:0] data_o
);

  logic slt;

  // Signed compare for set-less-than
  assign slt = $signed(rs1_i) < $signed(rs2_i);

  always_comb begin
    case (op_i)
      ADD: begin
        data_o = rs1_i + rs2_i;
      end
      SUB: begin
        data_o = rs1_i - rs2_i;
      end
      AND: begin
        data_o = rs1_i & rs2_i;
      end
      OR: begin
        data_o = rs1_i | rs2_i;
      end
      XOR: begin
        data_o = rs1_i ^ rs2_i;
      end
      SLT: begin
        data_o = {{(XLEN-1){1'b0}}, slt};
      end
      default: begin
        data_o = '0;
      end
    endcase
  end

endmodule

/* source/shifter.sv */
`timescale 1ns/100ps

module shifter import riscv_pkg::*; (
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  op_e             op_i,
  output logic [XLEN-1:0] data_o
);

  logic [4:0] shamt;

  // Only the low five bits count on RV32
  assign shamt = rs2_i[4:0];

  always_comb begin
    case (op_i)
      SLL: begin
        data_o = rs1_i << shamt;
      end
      SRL: begin
        data_o = rs1_i >> shamt;
      end
      SRA: begin
        data_o = $unsigned($signed(rs1_i) >>> shamt);
      end
      default: begin
        data_o = '0;
      end
    endcase
  end

endmodule

/* source/bu.sv */
`timescale 1ns/100ps

module bu import riscv_pkg::*; (
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] rs2_i,
  input  logic [XLEN-1:0] imm_i,
  input  logic [XLEN-1:0] pc_i,
  input  op_e             op_i,
  input  logic            unsign_i,
  output logic            taken_o,
  output logic [XLEN-1:0] pc_nxt_o,
  output logic [XLEN-1:0] link_o,
  output logic            misaligned_o
);

  logic            eq;
  logic            lt;
  logic [XLEN-1:0] jalr_sum;

  assign eq = rs1_i == rs2_i;
  assign lt = unsign_i ? (rs1_i < rs2_i) : ($signed(rs1_i) < $signed(rs2_i));

  always_comb begin
    case (op_i)
      BEQ:       taken_o = eq;
      BNE:       taken_o = ~eq;
      BLT:       taken_o = lt;
      JAL, JALR: taken_o = 1'b1;
      default:   taken_o = 1'b0;
    endcase
  end

  // JALR drops bit 0 of the sum
  assign jalr_sum = rs1_i + imm_i;
  assign pc_nxt_o = (op_i == JALR) ? {jalr_sum[XLEN-1:1], 1'b0} : pc_i + imm_i;

  // Return address for jumps, sequential pc otherwise
  assign link_o = pc_i + XLEN'(4);

  // No compressed instructions, targets must be word aligned
  assign misaligned_o = |pc_nxt_o[1:0];

endmodule

/* source/lsu.sv */
`timescale 1ns/100ps

module lsu import riscv_pkg::*; (
  input  logic [XLEN-1:0] rs1_i,
  input  logic [XLEN-1:0] imm_i,
  input  size_e           size_i,
  input  logic            unsign_i,
  input  logic [XLEN-1:0] rdata_i,
  output logic [XLEN-1:0] adr_o,
  output logic [XLEN-1:0] load_data_o,
  output logic            misaligned_o
);

  logic [7:0]  byte_sel;
  logic [15:0] half_sel;

  assign adr_o = rs1_i + imm_i;

  // Natural alignment per access size
  always_comb begin
    case (size_i)
      HALF:    misaligned_o = adr_o[0];
      WORD:    misaligned_o = |adr_o[1:0];
      default: misaligned_o = 1'b0;
    endcase
  end

  // Lane extraction from the read word
  assign byte_sel = rdata_i[{adr_o[1:0], 3'b000} +: 8];
  assign half_sel = rdata_i[{adr_o[1], 4'b0000} +: 16];

  always_comb begin
    case (size_i)
      BYTE: begin
        load_data_o = {{(XLEN-8){~unsign_i & byte_sel[7]}}, byte_sel};
      end
      HALF: begin
        load_data_o = {{(XLEN-16){~unsign_i & half_sel[15]}}, half_sel};
      end
      default: begin
        load_data_o = rdata_i;
      end
    endcase
  end

endmodule

/* source/exe.sv */
`timescale 1ns/100ps

module exe import riscv_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  dec_pkt_t        dec_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] mtvec_i,
  output mem_req_t        mem_o,
  input  logic [XLEN-1:0] rdata_i,
  output wbk_pkt_t        wbk_o,
  output trap_pkt_t       trap_o,
  output mode_e           mode_o,
  output logic [XLEN-1:0] fwd_rd_data_o,
  output logic [XLEN-1:0] fwd_csr_data_o
);

  // Unit results
  logic [XLEN-1:0] alu_data;
  logic [XLEN-1:0] sft_data;
  logic            bu_taken;
  logic [XLEN-1:0] bu_target;
  logic [XLEN-1:0] bu_link;
  logic            bu_misaligned;
  logic [XLEN-1:0] lsu_adr;
  logic [XLEN-1:0] lsu_data;
  logic            lsu_misaligned;

  logic            squash;
  logic            active;
  logic            is_lsu;
  logic            is_ld;
  logic            is_st;
  logic            taken;
  logic            f_pc;
  logic            f_ill;
  logic            f_ld;
  logic            f_st;
  logic            f_ecall;
  logic            exception_nxt;
  cause_e          cause_nxt;
  logic [XLEN-1:0] mtval_nxt;
  logic            redirect_nxt;
  logic [XLEN-1:0] pc_nxt;
  mode_e           mode_nxt;
  logic            rd_v_nxt;
  logic [XLEN-1:0] rd_data_nxt;
  logic            csr_v_nxt;
  logic [XLEN-1:0] csr_data_nxt;

  // Control flops
  logic            redirect_q;
  logic            redirect_dly_q;
  logic            rd_v_q;
  logic            csr_v_q;
  logic            exception_q;
  mode_e           mode_q;

  // Payload flops
  logic [4:0]      rd_adr_q;
  logic [XLEN-1:0] rd_data_q;
  logic [11:0]     csr_adr_q;
  logic [XLEN-1:0] csr_data_q;
  logic [XLEN-1:0] pc_nxt_q;
  cause_e          cause_q;
  logic [XLEN-1:0] mtval_q;
  logic [XLEN-1:0] mepc_q;

  // ------------------------------
  // Units
  // ------------------------------
  alu u_alu (
    .rs1_i  (dec_i.rs1),
    .rs2_i  (dec_i.rs2),
    .op_i   (dec_i.op),
    .data_o (alu_data)
  );

  shifter u_shifter (
    .rs1_i  (dec_i.rs1),
    .rs2_i  (dec_i.rs2),
    .op_i   (dec_i.op),
    .data_o (sft_data)
  );

  bu u_bu (
    .rs1_i        (dec_i.rs1),
    .rs2_i        (dec_i.rs2),
    .imm_i        (dec_i.imm),
    .pc_i         (dec_i.pc),
    .op_i         (dec_i.op),
    .unsign_i     (dec_i.unsign),
    .taken_o      (bu_taken),
    .pc_nxt_o     (bu_target),
    .link_o       (bu_link),
    .misaligned_o (bu_misaligned)
  );

  lsu u_lsu (
    .rs1_i        (dec_i.rs1),
    .imm_i        (dec_i.imm),
    .size_i       (dec_i.size),
    .unsign_i     (dec_i.unsign),
    .rdata_i      (rdata_i),
    .adr_o        (lsu_adr),
    .load_data_o  (lsu_data),
    .misaligned_o (lsu_misaligned)
  );

  // ------------------------------
  // Squash and faults
  // ------------------------------
  // Two instructions behind a redirect are already in flight
  assign squash = redirect_q | redirect_dly_q;
  assign active = dec_i.valid & ~squash;

  assign is_lsu = dec_i.unit == LSU;
  assign is_ld  = is_lsu & (dec_i.op == LD);
  assign is_st  = is_lsu & (dec_i.op == ST);
  assign taken  = (dec_i.unit == BU) & bu_taken;

  assign f_pc    = active & taken & bu_misaligned;
  assign f_ill   = active & dec_i.illegal;
  assign f_ld    = active & is_ld & lsu_misaligned;
  assign f_st    = active & is_st & lsu_misaligned;
  assign f_ecall = active & dec_i.ecall;

  assign exception_nxt = f_pc | f_ill | f_ld | f_st | f_ecall;

  // Highest priority first
  always_comb begin
    cause_nxt = PC_MISALIGNED;
    mtval_nxt = '0;
    if (f_pc) begin
      mtval_nxt = bu_target;
    end else if (f_ill) begin
      cause_nxt = ILLEGAL;
    end else if (f_ld) begin
      cause_nxt = LD_MISALIGNED;
      mtval_nxt = lsu_adr;
    end else if (f_st) begin
      cause_nxt = ST_MISALIGNED;
      mtval_nxt = lsu_adr;
    end else if (f_ecall) begin
      cause_nxt = ECALL_M;
    end
  end

  // Redirect target and privilege update
  always_comb begin
    redirect_nxt = 1'b0;
    pc_nxt       = bu_target;
    mode_nxt     = mode_q;
    if (exception_nxt) begin
      redirect_nxt = 1'b1;
      pc_nxt       = mtvec_i;
      mode_nxt     = MACHINE;
    end else if (active & dec_i.mret) begin
      redirect_nxt = 1'b1;
      pc_nxt       = mepc_i;
      mode_nxt     = USER;
    end else if (active & dec_i.sret) begin
      redirect_nxt = 1'b1;
      pc_nxt       = bu_link;
      mode_nxt     = SUPER;
    end else if (active & taken) begin
      redirect_nxt = 1'b1;
    end
  end

  // ------------------------------
  // Results
  // ------------------------------
  always_comb begin
    case (dec_i.unit)
      ALU:     rd_data_nxt = alu_data;
      SFT:     rd_data_nxt = sft_data;
      BU:      rd_data_nxt = bu_link;
      LSU:     rd_data_nxt = lsu_data;
      default: rd_data_nxt = '0;
    endcase
    // CSR reads return the old value, which arrives on rs2
    if (dec_i.csr_wbk) begin
      rd_data_nxt = dec_i.rs2;
    end
  end

  assign csr_data_nxt = dec_i.csrrw ? dec_i.rs1 : alu_data;
  assign rd_v_nxt     = active & dec_i.rd_v & ~exception_nxt;
  assign csr_v_nxt    = active & dec_i.csr_wbk & ~exception_nxt;

  always_comb begin
    mem_o.valid = dec_i.valid & is_lsu;
    mem_o.store = active & is_st & ~exception_nxt;
    mem_o.adr   = lsu_adr;
    mem_o.size  = dec_i.size;
    mem_o.wdata = dec_i.rs2;
  end

  // ------------------------------
  // Registers
  // ------------------------------
  always_ff @(posedge clk or negedge reset_n) begin
    if (!reset_n) begin
      redirect_q     <= 1'b0;
      redirect_dly_q <= 1'b0;
      rd_v_q         <= 1'b0;
      csr_v_q        <= 1'b0;
      exception_q    <= 1'b0;
      mode_q         <= MACHINE;
    end else begin
      redirect_q     <= redirect_nxt;
      redirect_dly_q <= redirect_q;
      rd_v_q         <= rd_v_nxt;
      csr_v_q        <= csr_v_nxt;
      exception_q    <= exception_nxt;
      mode_q         <= mode_nxt;
    end
  end

  always_ff @(posedge clk) begin
    rd_adr_q   <= dec_i.rd_adr;
    rd_data_q  <= rd_data_nxt;
    csr_adr_q  <= dec_i.csr_adr;
    csr_data_q <= csr_data_nxt;
    pc_nxt_q   <= pc_nxt;
    cause_q    <= cause_nxt;
    mtval_q    <= mtval_nxt;
    mepc_q     <= dec_i.pc;
  end

  always_comb begin
    wbk_o.rd_v      = rd_v_q;
    wbk_o.rd_adr    = rd_adr_q;
    wbk_o.rd_data   = rd_data_q;
    wbk_o.csr_v     = csr_v_q;
    wbk_o.csr_adr   = csr_adr_q;
    wbk_o.csr_data  = csr_data_q;
    wbk_o.branch_v  = redirect_q;
    wbk_o.pc_nxt    = pc_nxt_q;
    trap_o.exception = exception_q;
    trap_o.cause     = cause_q;
    trap_o.mtval     = mtval_q;
    trap_o.mepc      = mepc_q;
  end

  assign mode_o         = mode_q;
  assign fwd_rd_data_o  = rd_data_nxt;
  assign fwd_csr_data_o = csr_data_nxt;

endmodule

/* source/dmem.sv */
`timescale 1ns/100ps

module dmem import riscv_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  mem_req_t        req_i,
  output logic [XLEN-1:0] rdata_o
);

  localparam int AW = $clog2(MEM_WORDS);

  logic [XLEN-1:0] mem [MEM_WORDS];
  logic [AW-1:0]   idx;
  logic [3:0]      be;
  logic [XLEN-1:0] lane_data;

  assign idx = req_i.adr[AW+1:2];

  // Byte enables and store data replicated across lanes
  always_comb begin
    case (req_i.size)
      BYTE: begin
        be        = 4'b0001 << req_i.adr[1:0];
        lane_data = {4{req_i.wdata[7:0]}};
      end
      HALF: begin
        be        = 4'b0011 << {req_i.adr[1], 1'b0};
        lane_data = {2{req_i.wdata[15:0]}};
      end
      default: begin
        be        = 4'b1111;
        lane_data = req_i.wdata;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (req_i.valid && req_i.store) begin
      for (int i = 0; i < 4; i++) begin
        if (be[i]) begin
          mem[idx][8*i +: 8] <= lane_data[8*i +: 8];
        end
      end
    end
  end

  assign rdata_o = mem[idx];

endmodule

/* source/exe_top.sv */
`timescale 1ns/100ps

module exe_top import riscv_pkg::*; #(
  parameter int MEM_WORDS = 256
) (
  input  logic            clk,
  input  logic            reset_n,
  input  dec_pkt_t        dec_i,
  input  logic [XLEN-1:0] mepc_i,
  input  logic [XLEN-1:0] mtvec_i,
  output wbk_pkt_t        wbk_o,
  output trap_pkt_t       trap_o,
  output mode_e           mode_o,
  output logic [XLEN-1:0] fwd_rd_data_o,
  output logic [XLEN-1:0] fwd_csr_data_o
);

  // Stage to memory
  mem_req_t        mem_req;
  logic [XLEN-1:0] mem_rdata;

  exe u_exe (
    .clk            (clk),
    .reset_n        (reset_n),
    .dec_i          (dec_i),
    .mepc_i         (mepc_i),
    .mtvec_i        (mtvec_i),
    .mem_o          (mem_req),
    .rdata_i        (mem_rdata),
    .wbk_o          (wbk_o),
    .trap_o         (trap_o),
    .mode_o         (mode_o),
    .fwd_rd_data_o  (fwd_rd_data_o),
    .fwd_csr_data_o (fwd_csr_data_o)
  );

  dmem #(
    .MEM_WORDS (MEM_WORDS)
  ) u_dmem (
    .clk     (clk),
    .req_i   (mem_req),
    .rdata_o (mem_rdata)
  );

endmodule

/* sim/exe_props.sv */
`timescale 1ns/100ps

module exe_props import riscv_pkg::*; (
  input  logic            clk,
  input  logic            reset_n,
  input  wbk_pkt_t        wbk_i,
  input  trap_pkt_t       trap_i,
  input  mode_e           mode_i,
  input  logic            store_i,
  input  logic [XLEN-1:0] mtvec_i
);

  reset_values: assert property (@(posedge clk)
    !reset_n |-> !wbk_i.rd_v && !wbk_i.csr_v && !wbk_i.branch_v && !trap_i.exception &&
                 mode_i == MACHINE)
    else $error("Outputs are not at their reset values while reset is low");

  // Two instructions behind a redirect are squashed
  no_wbk_after_redirect: assert property (@(posedge clk) disable iff (!reset_n)
    ($past(wbk_i.branch_v) || $past(wbk_i.branch_v, 2)) |-> !wbk_i.rd_v)
    else $error("Register write within two cycles of a redirect");

  no_store_after_redirect: assert property (@(posedge clk) disable iff (!reset_n)
    (wbk_i.branch_v || $past(wbk_i.branch_v)) |-> !store_i)
    else $error("Store issued within two cycles of a redirect");

  trap_redirect: assert property (@(posedge clk) disable iff (!reset_n)
    trap_i.exception |-> wbk_i.branch_v && wbk_i.pc_nxt == mtvec_i && mode_i == MACHINE)
    else $error("Trap without redirect to the trap vector in machine mode");

endmodule

bind exe exe_props u_props (
  .clk     (clk),
  .reset_n (reset_n),
  .wbk_i   (wbk_o),
  .trap_i  (trap_o),
  .mode_i  (mode_o),
  .store_i (mem_o.store),
  .mtvec_i (mtvec_i)
);

/* sim/exe_tb.sv */
`timescale 1ns/100ps

module exe_tb import riscv_pkg::*; ();

  localparam int CLK_PERIOD    = 20;
  // Cycles used by the tests, rounded up
  localparam int TEST_CYCLES   = 60;
  localparam int MARGIN_CYCLES = 20;

  localparam logic [XLEN-1:0] MTVEC = 32'h0000_0800;
  localparam logic [XLEN-1:0] MEPC  = 32'h0000_0500;
  localparam dec_pkt_t        IDLE  = '0;

  logic            clk;
  logic            reset_n;
  dec_pkt_t        dec;
  logic [XLEN-1:0] mepc;
  logic [XLEN-1:0] mtvec;
  wbk_pkt_t        wbk;
  trap_pkt_t       trap;
  mode_e           mode;
  logic [XLEN-1:0] fwd_rd_data;
  logic [XLEN-1:0] fwd_csr_data;

  integer seed = 49;
  int     checks;
  int     errors;
  int     test_errors;
  int     tests_run;
  int     tests_failed;
  string  test_name;

  op_e alu_ops [9] = '{ADD, SUB, AND, OR, XOR, SLT, SLL, SRL, SRA};

  exe_top #(
    .MEM_WORDS (256)
  ) dut_i (
    .clk            (clk),
    .reset_n        (reset_n),
    .dec_i          (dec),
    .mepc_i         (mepc),
    .mtvec_i        (mtvec),
    .wbk_o          (wbk),
    .trap_o         (trap),
    .mode_o         (mode),
    .fwd_rd_data_o  (fwd_rd_data),
    .fwd_csr_data_o (fwd_csr_data)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
    $display("Timeout: the tests did not finish in the expected time");
    $display("Checks failed");
    $finish;
  end

  // ------------------------------
  // Reference model and helpers
  // ------------------------------
  function automatic logic [XLEN-1:0] alu_model(input op_e op, input logic [XLEN-1:0] a,
                                                input logic [XLEN-1:0] b);
    case (op)
      ADD:     return a + b;
      SUB:     return a - b;
      AND:     return a & b;
      OR:      return a | b;
      XOR:     return a ^ b;
      SLT:     return {31'd0, $signed(a) < $signed(b)};
      SLL:     return a << b[4:0];
      SRL:     return a >> b[4:0];
      // Vacated upper bits take the sign
      SRA:     return (a >> b[4:0]) | ({XLEN{a[XLEN-1]}} & ~({XLEN{1'b1}} >> b[4:0]));
      default: return '0;
    endcase
  endfunction

  function automatic dec_pkt_t make_pkt(input unit_e unit, input op_e op,
                                        input logic [XLEN-1:0] rs1, input logic [XLEN-1:0] rs2,
                                        input logic [XLEN-1:0] imm, input logic [XLEN-1:0] pc);
    dec_pkt_t p;
    p       = '0;
    p.valid = 1'b1;
    p.unit  = unit;
    p.op    = op;
    p.rs1   = rs1;
    p.rs2   = rs2;
    p.imm   = imm;
    p.pc    = pc;
    return p;
  endfunction

  // One instruction per cycle, outputs read mid-cycle
  task automatic step(input dec_pkt_t pkt);
    @(posedge clk);
    dec <= pkt;
    @(negedge clk);
  endtask

  task automatic check(input string what, input logic [XLEN-1:0] expected,
                       input logic [XLEN-1:0] actual);
    checks++;
    assert (actual === expected) else begin
      $display("Error %s %s: expected %h, actual %h", test_name, what, expected, actual);
      errors++;
      test_errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    tests_run++;
    if (test_errors == 0) begin
      $display("%s: pass", test_name);
    end else begin
      tests_failed++;
      $display("%s: FAIL with %0d errors", test_name, test_errors);
    end
  endtask

  // ------------------------------
  // Directed tests
  // ------------------------------
  initial begin
    dec_pkt_t        p;
    logic [XLEN-1:0] a;
    logic [XLEN-1:0] b;
    logic [XLEN-1:0] exp_data;
    logic [XLEN-1:0] mem_word;
    logic [7:0]      st_byte;
    unit_e           sel_unit;

    reset_n <= 1'b1;
    dec     <= IDLE;
    mepc    <= MEPC;
    mtvec   <= MTVEC;
    @(posedge clk);
    reset_n <= 1'b0;
    repeat (3) @(posedge clk);
    reset_n <= 1'b1;
    @(negedge clk);

    start_test("reset");
    check("rd_v", 32'd0, 32'(wbk.rd_v));
    check("csr_v", 32'd0, 32'(wbk.csr_v));
    check("branch_v", 32'd0, 32'(wbk.branch_v));
    check("exception", 32'd0, 32'(trap.exception));
    check("mode", 32'(MACHINE), 32'(mode));
    end_test();

    start_test("alu_shift");
    for (int i = 0; i < 9; i++) begin
      a = $random(seed);
      b = $random(seed);
      sel_unit = (alu_ops[i] inside {SLL, SRL, SRA}) ? SFT : ALU;
      p = make_pkt(sel_unit, alu_ops[i], a, b, 32'd0, 32'h100 + 32'(4 * i));
      p.rd_v   = 1'b1;
      p.rd_adr = 5'(i + 1);
      exp_data = alu_model(alu_ops[i], a, b);
      step(p);
      check("fwd_rd_data", exp_data, fwd_rd_data);
      step(IDLE);
      check("rd_v", 32'd1, 32'(wbk.rd_v));
      check("rd_adr", 32'(i + 1), 32'(wbk.rd_adr));
      check("rd_data", exp_data, wbk.rd_data);
    end
    end_test();

    start_test("csr");
    a = $random(seed);
    b = $random(seed);
    // csrrw writes rs1 straight through
    p = make_pkt(ALU, ADD, a, b, 32'd0, 32'h180);
    p.csr_wbk = 1'b1;
    p.csrrw   = 1'b1;
    p.csr_adr = 12'h340;
    step(p);
    check("csrrw fwd_csr_data", a, fwd_csr_data);
    // Other CSR ops write the ALU result
    p = make_pkt(ALU, OR, a, b, 32'd0, 32'h184);
    p.csr_wbk = 1'b1;
    p.csr_adr = 12'h305;
    step(p);
    check("csrrw csr_v", 32'd1, 32'(wbk.csr_v));
    check("csrrw csr_adr", 32'h340, 32'(wbk.csr_adr));
    check("csrrw csr_data", a, wbk.csr_data);
    check("csrrs fwd_csr_data", a | b, fwd_csr_data);
    step(IDLE);
    check("csrrs csr_v", 32'd1, 32'(wbk.csr_v));
    check("csrrs csr_adr", 32'h305, 32'(wbk.csr_adr));
    check("csrrs csr_data", a | b, wbk.csr_data);
    end_test();

    start_test("load_store");
    mem_word = $random(seed) | 32'h8000_0000;
    st_byte  = 8'hA5;
    p = make_pkt(LSU, ST, 32'h40, mem_word, 32'd0, 32'h200);
    p.size = WORD;
    step(p);
    p = make_pkt(LSU, ST, 32'h40, {24'h0, st_byte}, 32'd1, 32'h204);
    p.size = BYTE;
    step(p);
    // Byte store lands in lane 1 only
    mem_word[15:8] = st_byte;
    p = make_pkt(LSU, LD, 32'h40, 32'd0, 32'd1, 32'h208);
    p.size   = BYTE;
    p.rd_v   = 1'b1;
    p.rd_adr = 5'd10;
    step(p);
    exp_data = {{24{mem_word[15]}}, mem_word[15:8]};
    check("lb fwd_rd_data", exp_data, fwd_rd_data);
    p = make_pkt(LSU, LD, 32'h40, 32'd0, 32'd2, 32'h20c);
    p.size   = HALF;
    p.unsign = 1'b1;
    p.rd_v   = 1'b1;
    p.rd_adr = 5'd11;
    step(p);
    check("lb rd_data", exp_data, wbk.rd_data);
    exp_data = {16'h0, mem_word[31:16]};
    check("lhu fwd_rd_data", exp_data, fwd_rd_data);
    step(IDLE);
    check("lhu rd_adr", 32'd11, 32'(wbk.rd_adr));
    check("lhu rd_data", exp_data, wbk.rd_data);
    end_test();

    start_test("branch_squash");
    a = $random(seed);
    p = make_pkt(BU, BEQ, a, a, 32'h40, 32'h300);
    step(p);
    p = make_pkt(ALU, ADD, a, 32'd1, 32'd0, 32'h340);
    p.rd_v   = 1'b1;
    p.rd_adr = 5'd5;
    step(p);
    check("branch_v", 32'd1, 32'(wbk.branch_v));
    check("pc_nxt", 32'h300 + 32'h40, wbk.pc_nxt);
    p.rd_adr = 5'd6;
    p.pc     = 32'h344;
    step(p);
    check("first squashed rd_v", 32'd0, 32'(wbk.rd_v));
    p.rd_adr = 5'd7;
    p.pc     = 32'h348;
    step(p);
    check("second squashed rd_v", 32'd0, 32'(wbk.rd_v));
    step(IDLE);
    check("rd_v", 32'd1, 32'(wbk.rd_v));
    check("rd_adr", 32'd7, 32'(wbk.rd_adr));
    check("rd_data", a + 32'd1, wbk.rd_data);
    end_test();

    start_test("trap_priority");
    p = make_pkt(LSU, LD, 32'h200, 32'd0, 32'd2, 32'h400);
    p.size   = WORD;
    p.rd_v   = 1'b1;
    p.rd_adr = 5'd3;
    step(p);
    // Stores in the trap shadow must not reach memory
    p = make_pkt(LSU, ST, 32'h80, 32'hDEAD_BEEF, 32'd0, 32'h404);
    p.size = WORD;
    step(p);
    check("exception", 32'd1, 32'(trap.exception));
    check("cause", 32'(LD_MISALIGNED), 32'(trap.cause));
    check("mtval", 32'h200 + 32'd2, trap.mtval);
    check("mepc", 32'h400, trap.mepc);
    check("branch_v", 32'd1, 32'(wbk.branch_v));
    check("pc_nxt", MTVEC, wbk.pc_nxt);
    check("rd_v", 32'd0, 32'(wbk.rd_v));
    p.pc = 32'h408;
    step(p);
    // Illegal outranks the misaligned store
    p = make_pkt(LSU, ST, 32'h201, 32'h1234, 32'd0, 32'h40c);
    p.size    = HALF;
    p.illegal = 1'b1;
    step(p);
    step(IDLE);
    check("exception", 32'd1, 32'(trap.exception));
    check("cause", 32'(ILLEGAL), 32'(trap.cause));
    check("mtval", 32'd0, trap.mtval);
    check("mepc", 32'h40c, trap.mepc);
    step(IDLE);
    end_test();

    start_test("privilege");
    p = make_pkt(NONE, ADD, 32'd0, 32'd0, 32'd0, 32'h480);
    p.mret = 1'b1;
    step(p);
    step(IDLE);
    check("mret branch_v", 32'd1, 32'(wbk.branch_v));
    check("mret pc_nxt", MEPC, wbk.pc_nxt);
    check("mret mode", 32'(USER), 32'(mode));
    step(IDLE);
    p = make_pkt(NONE, ADD, 32'd0, 32'd0, 32'd0, 32'h600);
    p.sret = 1'b1;
    step(p);
    step(IDLE);
    check("sret pc_nxt", 32'h600 + 32'd4, wbk.pc_nxt);
    check("sret mode", 32'(SUPER), 32'(mode));
    step(IDLE);
    p = make_pkt(NONE, ADD, 32'd0, 32'd0, 32'd0, 32'h700);
    p.ecall = 1'b1;
    step(p);
    step(IDLE);
    check("ecall exception", 32'd1, 32'(trap.exception));
    check("ecall cause", 32'(ECALL_M), 32'(trap.cause));
    check("ecall mepc", 32'h700, trap.mepc);
    check("ecall pc_nxt", MTVEC, wbk.pc_nxt);
    check("ecall mode", 32'(MACHINE), 32'(mode));
    end_test();

    $display("Tests %0d run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

/* src.f */
source/riscv_pkg.sv
source/alu.sv
source/shifter.sv
source/bu.sv
source/lsu.sv
source/exe.sv
source/dmem.sv
source/exe_top.sv
sim/exe_props.sv
sim/exe_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the execute stage testbench with Verilator
set -e
set -o pipefail

verilator --binary --assert --top-module exe_tb -f src.f -o exe_sim
./obj_dir/exe_sim | tee sim.log

if grep -q "All checks passed" sim.log; then
  echo "Simulation passed"
else
  echo "Simulation failed"
  exit 1
fi
